// File: include/led_consts.svh
/*
 * board constants for the status LED subsystem:
 * channel count, chain length, shift clock prescale,
 * activity stretch length and serial data polarity
 */
`ifndef LED_CONSTS_SVH
`define LED_CONSTS_SVH

// status channels, each one a red/green pair
`define LED_CHANNELS 8

// LEDs on the external shift-register chain
`define LED_COUNT (2 * `LED_CHANNELS)

// driver ticks once every LED_PRESCALE+1 clk cycles
`define LED_PRESCALE 3

// cycles an activity level is held after the last strobe
`define LED_STRETCH 512

// LEDs are active low on this board, so serial data is inverted
`define LED_INVERT 1

`endif

// File: src/led_pkg.sv
/*
 * shared types for the status LED subsystem:
 * per-channel vectors, interleaved LED vector,
 * stretch counter and serial driver states
 */
`include "led_consts.svh"

package led_pkg;

    typedef logic [`LED_CHANNELS-1:0] chan_vec_t;

    // red at 2i, green at 2i+1
    typedef logic [`LED_COUNT-1:0] led_vec_t;

    typedef logic [$clog2(`LED_STRETCH + 1)-1:0] stretch_cnt_t;

    typedef enum logic [1:0] {
        st_idle,
        st_shift_lo,
        st_shift_hi,
        st_load
    } sreg_state_t;

endpackage

// File: src/status_capture.sv
/*
 * status input capture:
 * activity pulse stretchers, one per channel,
 * and sticky error flags with a shared clear
 */
`include "led_consts.svh"

module status_capture
    import led_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  chan_vec_t act,
    input  chan_vec_t err,
    input  logic      err_clear,

    output chan_vec_t act_level,
    output chan_vec_t err_flag
);

    localparam stretch_cnt_t STRETCH_LOAD = stretch_cnt_t'(`LED_STRETCH);

    stretch_cnt_t act_cnt [`LED_CHANNELS];
    chan_vec_t    err_q;

    // per-channel down counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `LED_CHANNELS; i++) begin
                act_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `LED_CHANNELS; i++) begin
                if (act[i]) begin
                    // a new strobe restarts the hold time
                    act_cnt[i] <= STRETCH_LOAD;
                end else if (act_cnt[i] != '0) begin
                    act_cnt[i] <= act_cnt[i] - 1'b1;
                end
            end
        end
    end

    // level is high while the count runs
    always_comb begin
        for (int i = 0; i < `LED_CHANNELS; i++) begin
            act_level[i] = (act_cnt[i] != '0);
        end
    end

    // sticky flags, a set in the clear cycle wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            err_q <= '0;
        end else if (err_clear) begin
            err_q <= err;
        end else begin
            err_q <= err_q | err;
        end
    end

    assign err_flag = err_q;

endmodule

// File: src/led_pattern.sv
/*
 * LED pattern stage:
 * red/green levels per channel, interleaved vector
 * for the shift chain and the two-bit summary
 */
module led_pattern
    import led_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  chan_vec_t act_level,
    input  chan_vec_t err_flag,

    output led_vec_t  led_vec,
    output logic [1:0] led_bmc
);

    chan_vec_t led_red;
    chan_vec_t led_green;
    led_vec_t  led_merged;

    // errors show red, activity shows green
    assign led_red   = err_flag;
    assign led_green = act_level;

    // red bit first, then green, channel 0 at the bottom
    always_comb begin
        for (int i = 0; i < $bits(chan_vec_t); i++) begin
            led_merged[2*i]   = led_red[i];
            led_merged[2*i+1] = led_green[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led_vec <= '0;
            led_bmc <= 2'b00;
        end else begin
            led_vec <= led_merged;
            // any error on bit 0, any activity on bit 1
            led_bmc[0] <= |led_red;
            led_bmc[1] <= |led_green;
        end
    end

endmodule

// File: src/led_sreg_driver.sv
/*
 * serial driver for the external LED shift-register chain:
 * prescaled tick, MSB-first shifting with sreg_clk,
 * one-tick load pulse, new frame only on a change
 */
`include "led_consts.svh"

module led_sreg_driver
    import led_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,

    input  led_vec_t led_vec,

    output logic     sreg_d,
    output logic     sreg_clk,
    output logic     sreg_ld
);

    localparam int unsigned PRE_W = $clog2(`LED_PRESCALE + 2);
    localparam int unsigned IDX_W = $clog2(`LED_COUNT);
    localparam logic        INV_BIT = (`LED_INVERT != 0);

    logic [PRE_W-1:0] pre_cnt;
    logic             tick;

    sreg_state_t      state;
    logic [IDX_W-1:0] bit_idx;
    logic             frame_req;
    logic             start;

    led_vec_t         shift_q;
    led_vec_t         last_vec;

    // free-running prescaler
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= PRE_W'(`LED_PRESCALE);
        end else begin
            pre_cnt <= pre_cnt - 1'b1;
        end
    end

    assign tick = (pre_cnt == '0);

    // frame after reset, and whenever the vector moved
    assign start = tick && (state == st_idle) && (frame_req || (led_vec != last_vec));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= st_idle;
            bit_idx   <= '0;
            frame_req <= 1'b1;
            sreg_d    <= INV_BIT;
            sreg_clk  <= 1'b0;
            sreg_ld   <= 1'b0;
        end else if (start) begin
            frame_req <= 1'b0;
            bit_idx   <= IDX_W'(`LED_COUNT - 1);
            sreg_d    <= led_vec[`LED_COUNT-1] ^ INV_BIT;
            sreg_clk  <= 1'b0;
            state     <= st_shift_lo;
        end else if (tick) begin
            case (state)
                st_shift_lo: begin
                    sreg_clk <= 1'b1;
                    state    <= st_shift_hi;
                end
                st_shift_hi: begin
                    sreg_clk <= 1'b0;
                    if (bit_idx == '0) begin
                        // whole chain filled, latch it
                        sreg_d  <= INV_BIT;
                        sreg_ld <= 1'b1;
                        state   <= st_load;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                        sreg_d  <= shift_q[`LED_COUNT-1] ^ INV_BIT;
                        state   <= st_shift_lo;
                    end
                end
                st_load: begin
                    sreg_ld <= 1'b0;
                    state   <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // snapshot and remaining bits, MSB leaves first
    always_ff @(posedge clk) begin
        if (start) begin
            last_vec <= led_vec;
            shift_q  <= led_vec << 1;
        end else if (tick && state == st_shift_hi && bit_idx != '0) begin
            shift_q <= shift_q << 1;
        end
    end

endmodule

// File: src/fpga_led.sv
/*
 * status LED top level:
 * input capture, pattern stage and serial chain driver
 */
module fpga_led
    import led_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       err_clear,

    input  chan_vec_t  act,
    input  chan_vec_t  err,

    // external LED shift-register chain
    output logic       sreg_d,
    output logic       sreg_clk,
    output logic       sreg_ld,

    output logic [1:0] led_bmc
);

    chan_vec_t act_level;
    chan_vec_t err_flag;
    led_vec_t  led_vec;

    status_capture status_capture_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .act       (act),
        .err       (err),
        .err_clear (err_clear),
        .act_level (act_level),
        .err_flag  (err_flag)
    );

    led_pattern led_pattern_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .act_level (act_level),
        .err_flag  (err_flag),
        .led_vec   (led_vec),
        .led_bmc   (led_bmc)
    );

    // serial chain sits on the board, one frame behind led_vec
    led_sreg_driver led_sreg_driver_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .led_vec  (led_vec),
        .sreg_d   (sreg_d),
        .sreg_clk (sreg_clk),
        .sreg_ld  (sreg_ld)
    );

endmodule

// File: testbench/fpga_led_chk.sv
/*
 * protocol checker for the LED shift-register chain:
 * clock and load exclusion, high phase lengths,
 * pulses per frame and data levels, bound to fpga_led
 */
`include "led_consts.svh"

module fpga_led_chk (
    input logic clk,
    input logic rst_n,
    input logic sreg_d,
    input logic sreg_clk,
    input logic sreg_ld
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HIGH_CYCLES = `LED_PRESCALE + 1;
    localparam logic IDLE_D = (`LED_INVERT != 0);

    int          fail_cnt = 0;
    int unsigned clk_pulses;
    logic        sreg_clk_q;

    // rising sreg_clk edges since the last load
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sreg_clk_q <= 1'b0;
            clk_pulses <= 0;
        end else begin
            sreg_clk_q <= sreg_clk;
            if (sreg_ld) begin
                clk_pulses <= 0;
            end else if (sreg_clk && !sreg_clk_q) begin
                clk_pulses <= clk_pulses + 1;
            end
        end
    end

    ld_clk_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(sreg_ld && sreg_clk))
        else begin
            fail_cnt++;
            $error("sreg_ld went high while sreg_clk was high");
        end

    clk_high_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sreg_clk) |-> sreg_clk [*HIGH_CYCLES] ##1 !sreg_clk)
        else begin
            fail_cnt++;
            $error("sreg_clk high phase had the wrong length");
        end

    ld_high_len: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sreg_ld) |-> sreg_ld [*HIGH_CYCLES] ##1 !sreg_ld)
        else begin
            fail_cnt++;
            $error("sreg_ld high phase had the wrong length");
        end

    pulses_per_frame: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sreg_ld) |-> (clk_pulses == `LED_COUNT))
        else begin
            fail_cnt++;
            $error("error clk_pulses 0x%h expected 0x%h", $sampled(clk_pulses), `LED_COUNT);
        end

    // data must not move under a high shift clock
    d_stable_clk_high: assert property (@(posedge clk) disable iff (!rst_n)
        sreg_clk |-> $stable(sreg_d))
        else begin
            fail_cnt++;
            $error("sreg_d changed while sreg_clk was high");
        end

    d_idle_in_load: assert property (@(posedge clk) disable iff (!rst_n)
        sreg_ld |-> (sreg_d == IDLE_D))
        else begin
            fail_cnt++;
            $error("error sreg_d 0x%h expected 0x%h", $sampled(sreg_d), IDLE_D);
        end

endmodule

bind fpga_led fpga_led_chk fpga_led_chk_inst (
    .clk      (clk),
    .rst_n    (rst_n),
    .sreg_d   (sreg_d),
    .sreg_clk (sreg_clk),
    .sreg_ld  (sreg_ld)
);

// File: testbench/tb_fpga_led.sv
/*
 * testbench for the status LED top level:
 * clock, reset, strobes, external chain model,
 * watchdog and final result
 */
`include "led_consts.svh"

module tb_fpga_led
    import led_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 8;
    localparam int FRAME_CYCLES = (2 * `LED_COUNT + 2) * (`LED_PRESCALE + 1);
    localparam int TEST_FRAMES = 16;
    localparam int WATCHDOG_CYCLES = (TEST_FRAMES + 4) * FRAME_CYCLES + `LED_STRETCH + 200;
    localparam logic INV = (`LED_INVERT != 0);

    logic       clk;
    logic       rst_n;
    logic       err_clear;
    chan_vec_t  act;
    chan_vec_t  err;
    logic       sreg_d;
    logic       sreg_clk;
    logic       sreg_ld;
    logic [1:0] led_bmc;

    led_vec_t    chain = '0;
    led_vec_t    chain_q = '1;
    led_vec_t    exp_vec;
    int unsigned frame_cnt = 0;
    chan_vec_t   act_mask;
    chan_vec_t   err_mask;
    integer      seed;

    fpga_led fpga_led_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .err_clear (err_clear),
        .act       (act),
        .err       (err),
        .sreg_d    (sreg_d),
        .sreg_clk  (sreg_clk),
        .sreg_ld   (sreg_ld),
        .led_bmc   (led_bmc)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // board chain model where the first bit shifted ends up at the top
    always @(posedge sreg_clk) begin
        chain <= {chain[`LED_COUNT-2:0], sreg_d};
    end

    always @(posedge sreg_ld) begin
        chain_q   <= chain ^ {`LED_COUNT{INV}};
        frame_cnt <= frame_cnt + 1;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TESTS FAILED");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_vec(input string name, input led_vec_t got, input led_vec_t exp);
        assert (got == exp)
            else report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
            else report_failure($sformatf("error %s got 0x%h expected 0x%h", name, got, exp));
    endtask

    // LED k belongs to channel k/2, red on even k and green on odd k
    function automatic led_vec_t interleave(input chan_vec_t red, input chan_vec_t green);
        led_vec_t v;
        for (int k = 0; k < `LED_COUNT; k++) begin
            v[k] = (k % 2 == 0) ? red[k / 2] : green[k / 2];
        end
        return v;
    endfunction

    task automatic drive_strobes(input chan_vec_t act_in, input chan_vec_t err_in,
                                 input logic clear_in);
        @(posedge clk);
        #1;
        act       = act_in;
        err       = err_in;
        err_clear = clear_in;
        @(posedge clk);
        #1;
        act       = '0;
        err       = '0;
        err_clear = 1'b0;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    // a stale frame in flight plus a fresh one
    task automatic wait_frames(input int n);
        wait_cycles(n * FRAME_CYCLES + 8);
    endtask

    function automatic chan_vec_t random_mask();
        chan_vec_t m;
        m = chan_vec_t'($random(seed));
        if (m == '0) begin
            m = chan_vec_t'(1);
        end
        return m;
    endfunction

    always @(posedge clk) begin
        if (fpga_led_inst.fpga_led_chk_inst.fail_cnt != 0) begin
            report_failure("a protocol assertion in the bound checker failed");
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure("watchdog expired before the tests finished");
    end

    initial begin
        int unsigned ch;
        seed      = 32'hc8da_7944;
        rst_n     = 1'b0;
        err_clear = 1'b0;
        act       = '0;
        err       = '0;
        act_mask  = '0;
        err_mask  = '0;
        exp_vec   = '0;

        repeat (3) @(posedge clk);
        #1;
        check_bit("sreg_clk", sreg_clk, 1'b0);
        check_bit("sreg_ld", sreg_ld, 1'b0);
        check_bit("sreg_d", sreg_d, INV);
        check_vec("led_bmc", led_vec_t'(led_bmc), '0);
        rst_n = 1'b1;

        // first frame after reset shows all LEDs off
        wait (frame_cnt == 1);
        wait_cycles(1);
        check_vec("chain_q", chain_q, exp_vec);

        // activity on random channels
        act_mask = random_mask();
        drive_strobes(act_mask, '0, 1'b0);
        exp_vec = interleave(err_mask, act_mask);
        wait_frames(2);
        check_vec("chain_q", chain_q, exp_vec);
        check_bit("led_bmc[1]", led_bmc[1], 1'b1);

        // stretch runs out
        act_mask = '0;
        exp_vec  = interleave(err_mask, act_mask);
        wait_cycles(`LED_STRETCH);
        wait_frames(2);
        check_vec("chain_q", chain_q, exp_vec);
        check_bit("led_bmc[1]", led_bmc[1], 1'b0);

        // sticky errors, then clear
        err_mask = random_mask();
        drive_strobes('0, err_mask, 1'b0);
        exp_vec = interleave(err_mask, act_mask);
        wait_frames(2);
        check_vec("chain_q", chain_q, exp_vec);
        check_bit("led_bmc[0]", led_bmc[0], 1'b1);
        wait_frames(3);
        check_vec("chain_q", chain_q, exp_vec);
        check_bit("led_bmc[0]", led_bmc[0], 1'b1);
        drive_strobes('0, '0, 1'b1);
        err_mask = '0;
        exp_vec  = interleave(err_mask, act_mask);
        wait_frames(2);
        check_vec("chain_q", chain_q, exp_vec);
        check_bit("led_bmc[0]", led_bmc[0], 1'b0);

        // set and clear in one cycle leave the set in place
        ch       = $unsigned($random(seed)) % `LED_CHANNELS;
        err_mask = chan_vec_t'(1) << ((ch + 1) % `LED_CHANNELS);
        drive_strobes('0, err_mask, 1'b0);
        exp_vec = interleave(err_mask, act_mask);
        wait_frames(2);
        check_vec("chain_q", chain_q, exp_vec);
        err_mask = chan_vec_t'(1) << ch;
        drive_strobes('0, err_mask, 1'b1);
        exp_vec = interleave(err_mask, act_mask);
        wait_frames(2);
        check_vec("chain_q", chain_q, exp_vec);
        check_bit("led_bmc[0]", led_bmc[0], 1'b1);

        if (fpga_led_inst.fpga_led_chk_inst.fail_cnt == 0) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            report_failure("a protocol assertion in the bound checker failed");
        end
    end

endmodule

// File: src.f
+incdir+include
src/led_pkg.sv
src/status_capture.sv
src/led_pattern.sv
src/led_sreg_driver.sv
src/fpga_led.sv
testbench/fpga_led_chk.sv
testbench/tb_fpga_led.sv
